/* rs_pkg.sv */
//##########################################################################
// Reservation station package
// Tag, operand and CDB types shared by the add and multiply stations,
// with the station tag map and the station FSM states
//##########################################################################
package rs_pkg;

	// tag map
	//   0      operand present, nothing to wait for
	//   1..6   load buffers, external CDB producers only
	//   7..9   add stations 1..3
	//   10..11 multiply stations 1..2
	typedef logic [3:0]  rs_tag_t;
	typedef logic [31:0] rs_value_t;
	typedef logic [2:0]  rs_op_t;   // passed to the execution unit untouched

	localparam rs_tag_t TAG_NONE = 4'd0;

	localparam int NUM_CDB      = 6;   // five unit result buses plus the load bus
	localparam int ADD_TAG_BASE = 7;
	localparam int MUL_TAG_BASE = 10;

	// one result bus, the producer drives its own tag
	typedef struct packed {
		logic      valid;
		rs_tag_t   tag;
		rs_value_t value;
	} cdb_bus_t;

	// issue request broadcast to every station
	typedef struct packed {
		rs_tag_t   target;   // tag of the station that takes the instruction
		rs_op_t    op;
		rs_value_t vj;       // register file value, used when qj is zero
		rs_value_t vk;
		rs_tag_t   qj;       // producer of vj
		rs_tag_t   qk;
	} issue_t;

	// station to execution unit
	typedef struct packed {
		logic      start;    // one cycle pulse
		rs_op_t    op;
		rs_value_t vj;
		rs_value_t vk;
	} dispatch_t;

	typedef enum logic [1:0] {
		IDLE          = 2'd0,
		WAIT_OPERANDS = 2'd1,
		READY         = 2'd2,
		EXECUTE       = 2'd3
	} station_state_t;

endpackage

/* cdb_snoop.sv */
//##########################################################################
// CDB snoop
// Compares one waiting producer tag with every common data bus and
// returns the word of the matching bus, lowest bus first
//##########################################################################
`timescale 1ns/100ps

module cdb_snoop #(
	parameter int NUM_CDB = rs_pkg::NUM_CDB
) (
	input  rs_pkg::rs_tag_t                 tag,
	input  rs_pkg::cdb_bus_t [NUM_CDB-1:0]  cdb,
	output logic                            hit,
	output rs_pkg::rs_value_t               value
);

	logic [NUM_CDB-1:0] match;

	// plain tag equality on every bus
	always_comb begin
		for (int i = 0; i < NUM_CDB; i++) begin
			match[i] = cdb[i].valid && (cdb[i].tag == tag);
		end
	end

	// tag zero is never a wait, so it can not hit
	assign hit = (tag != rs_pkg::TAG_NONE) && (|match);

	// walk down so the lowest numbered bus is the last to write
	always_comb begin
		value = '0;
		for (int i = NUM_CDB - 1; i >= 0; i--) begin
			if (match[i]) begin
				value = cdb[i].value;
			end
		end
	end

endmodule

/* rs_station.sv */
//##########################################################################
// Reservation station
// Holds one instruction until both operands are present, fires a one
// cycle start to its execution unit and frees itself on its own CDB tag
//##########################################################################
`timescale 1ns/100ps

module rs_station #(
	parameter rs_pkg::rs_tag_t MY_TAG  = 4'd7,
	parameter int              NUM_CDB = rs_pkg::NUM_CDB
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            select,
	input  rs_pkg::issue_t                  issue,
	input  rs_pkg::cdb_bus_t [NUM_CDB-1:0]  cdb,
	output rs_pkg::dispatch_t               dispatch,
	output logic                            busy,
	output logic                            accepted,
	output logic                            released
);

	rs_pkg::station_state_t state;
	rs_pkg::station_state_t state_next;

	rs_pkg::rs_op_t    op_r;
	rs_pkg::rs_value_t vj_r;
	rs_pkg::rs_value_t vk_r;
	rs_pkg::rs_tag_t   qj_r;
	rs_pkg::rs_tag_t   qk_r;

	rs_pkg::rs_tag_t   snoop_qj;
	rs_pkg::rs_tag_t   snoop_qk;
	logic              j_hit;
	logic              k_hit;
	rs_pkg::rs_value_t j_value;
	rs_pkg::rs_value_t k_value;
	logic              j_ok;
	logic              k_ok;
	logic              own_hit;

	// while idle the snoops look at the incoming tags for forwarding at issue
	assign snoop_qj = (state == rs_pkg::IDLE) ? issue.qj : qj_r;
	assign snoop_qk = (state == rs_pkg::IDLE) ? issue.qk : qk_r;

	cdb_snoop #(.NUM_CDB(NUM_CDB)) snoop_j_i (
		.tag   (snoop_qj),
		.cdb   (cdb),
		.hit   (j_hit),
		.value (j_value)
	);

	cdb_snoop #(.NUM_CDB(NUM_CDB)) snoop_k_i (
		.tag   (snoop_qk),
		.cdb   (cdb),
		.hit   (k_hit),
		.value (k_value)
	);

	assign j_ok = (snoop_qj == rs_pkg::TAG_NONE) || j_hit;   // operand held after this edge
	assign k_ok = (snoop_qk == rs_pkg::TAG_NONE) || k_hit;

	always_comb begin
		own_hit = 1'b0;
		for (int i = 0; i < NUM_CDB; i++) begin
			if (cdb[i].valid && (cdb[i].tag == MY_TAG)) begin
				own_hit = 1'b1;
			end
		end
	end

	assign busy     = (state != rs_pkg::IDLE);
	assign accepted = select && (state == rs_pkg::IDLE);   // issue to a busy station is lost
	assign released = (state == rs_pkg::EXECUTE) && own_hit;

	always_comb begin
		state_next = state;
		case (state)
			rs_pkg::IDLE: begin
				if (select) begin
					state_next = (j_ok && k_ok) ? rs_pkg::READY : rs_pkg::WAIT_OPERANDS;
				end
			end
			rs_pkg::WAIT_OPERANDS: begin
				if (j_ok && k_ok) begin
					state_next = rs_pkg::READY;
				end
			end
			rs_pkg::READY: state_next = rs_pkg::EXECUTE;   // start goes out this cycle
			rs_pkg::EXECUTE: begin
				if (own_hit) begin
					state_next = rs_pkg::IDLE;
				end
			end
			default: state_next = rs_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= rs_pkg::IDLE;
			qj_r  <= rs_pkg::TAG_NONE;
			qk_r  <= rs_pkg::TAG_NONE;
		end else begin
			state <= state_next;
			if (accepted) begin
				qj_r <= j_ok ? rs_pkg::TAG_NONE : issue.qj;
				qk_r <= k_ok ? rs_pkg::TAG_NONE : issue.qk;
			end else if (state == rs_pkg::WAIT_OPERANDS) begin
				if (j_hit) begin
					qj_r <= rs_pkg::TAG_NONE;
				end
				if (k_hit) begin
					qk_r <= rs_pkg::TAG_NONE;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accepted) begin
			op_r <= issue.op;
			vj_r <= (issue.qj == rs_pkg::TAG_NONE) ? issue.vj : j_value;
			vk_r <= (issue.qk == rs_pkg::TAG_NONE) ? issue.vk : k_value;
		end else if (state == rs_pkg::WAIT_OPERANDS) begin
			if (j_hit) begin
				vj_r <= j_value;
			end
			if (k_hit) begin
				vk_r <= k_value;
			end
		end
	end

	always_comb begin
		dispatch.start = (state == rs_pkg::READY);
		dispatch.op    = op_r;
		dispatch.vj    = vj_r;
		dispatch.vk    = vk_r;
	end

	// a station only starts once both held tags are cleared
	assert property (@(posedge clk) disable iff (!arst_n)
		dispatch.start |-> (qj_r == rs_pkg::TAG_NONE) && (qk_r == rs_pkg::TAG_NONE));

	// the top level decode must only pick a free station
	assert property (@(posedge clk) disable iff (!arst_n) !(select && busy))
		else $error("issue to busy station %0d", MY_TAG);

endmodule

/* rs_free_counter.sv */
//##########################################################################
// Free station counter
// Tracks how many add and multiply stations are free, from the issue
// accept and CDB release pulses of every station
//##########################################################################
`timescale 1ns/100ps

module rs_free_counter #(
	parameter int NUM_ADD = 3,
	parameter int NUM_MUL = 2
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic [NUM_ADD-1:0]             add_accept,
	input  logic [NUM_ADD-1:0]             add_release,
	input  logic [NUM_MUL-1:0]             mul_accept,
	input  logic [NUM_MUL-1:0]             mul_release,
	output logic [$clog2(NUM_ADD+1)-1:0]   add_free,
	output logic [$clog2(NUM_MUL+1)-1:0]   mul_free
);

	localparam int ADD_W = $clog2(NUM_ADD + 1);
	localparam int MUL_W = $clog2(NUM_MUL + 1);

	logic [ADD_W-1:0] add_next;
	logic [MUL_W-1:0] mul_next;

	// accepts and releases may land in the same cycle on different stations
	function automatic int next_count(int cur, int acc, int rel, int size);
		int sum;
		sum = cur + rel - acc;
		if (sum < 0) begin
			return 0;
		end
		if (sum > size) begin
			return size;
		end
		return sum;
	endfunction

	always_comb begin
		add_next = ADD_W'(next_count(int'(add_free), $countones(add_accept),
			$countones(add_release), NUM_ADD));
		mul_next = MUL_W'(next_count(int'(mul_free), $countones(mul_accept),
			$countones(mul_release), NUM_MUL));
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			add_free <= ADD_W'(NUM_ADD);   // every station free out of reset
			mul_free <= MUL_W'(NUM_MUL);
		end else begin
			add_free <= add_next;
			mul_free <= mul_next;
		end
	end

	// the clamp in next_count should never have to act
	assert property (@(posedge clk) disable iff (!arst_n)
		(int'(add_free) + $countones(add_release) >= $countones(add_accept)) &&
		(int'(add_free) + $countones(add_release) - $countones(add_accept) <= NUM_ADD));

	assert property (@(posedge clk) disable iff (!arst_n)
		(int'(mul_free) + $countones(mul_release) >= $countones(mul_accept)) &&
		(int'(mul_free) + $countones(mul_release) - $countones(mul_accept) <= NUM_MUL));

endmodule

/* rs_top.sv */
//##########################################################################
// Arithmetic reservation stations
// Decodes the issue target, holds the add and multiply stations and
// keeps the per class count of free stations
//##########################################################################
`timescale 1ns/100ps

module rs_top #(
	parameter int NUM_ADD = 3,
	parameter int NUM_MUL = 2
) (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    issue_valid,
	input  rs_pkg::issue_t                          issue,
	input  rs_pkg::cdb_bus_t [rs_pkg::NUM_CDB-1:0]  cdb,
	output rs_pkg::dispatch_t [NUM_ADD-1:0]         add_dispatch,
	output rs_pkg::dispatch_t [NUM_MUL-1:0]         mul_dispatch,
	output logic [NUM_ADD-1:0]                      add_busy,
	output logic [NUM_MUL-1:0]                      mul_busy,
	output logic [$clog2(NUM_ADD+1)-1:0]            add_free,
	output logic [$clog2(NUM_MUL+1)-1:0]            mul_free
);

	logic [NUM_ADD-1:0] add_select;
	logic [NUM_ADD-1:0] add_accept;
	logic [NUM_ADD-1:0] add_release;
	logic [NUM_MUL-1:0] mul_select;
	logic [NUM_MUL-1:0] mul_accept;
	logic [NUM_MUL-1:0] mul_release;

	// a target that matches no station selects nothing and is dropped
	for (genvar i = 0; i < NUM_ADD; i++) begin : g_add
		localparam rs_pkg::rs_tag_t TAG = rs_pkg::rs_tag_t'(rs_pkg::ADD_TAG_BASE + i);

		assign add_select[i] = issue_valid && (issue.target == TAG);

		rs_station #(
			.MY_TAG  (TAG),
			.NUM_CDB (rs_pkg::NUM_CDB)
		) rs_add_i (
			.clk      (clk),
			.arst_n   (arst_n),
			.select   (add_select[i]),
			.issue    (issue),
			.cdb      (cdb),
			.dispatch (add_dispatch[i]),
			.busy     (add_busy[i]),
			.accepted (add_accept[i]),
			.released (add_release[i])
		);
	end

	for (genvar i = 0; i < NUM_MUL; i++) begin : g_mul
		localparam rs_pkg::rs_tag_t TAG = rs_pkg::rs_tag_t'(rs_pkg::MUL_TAG_BASE + i);

		assign mul_select[i] = issue_valid && (issue.target == TAG);

		rs_station #(
			.MY_TAG  (TAG),
			.NUM_CDB (rs_pkg::NUM_CDB)
		) rs_mul_i (
			.clk      (clk),
			.arst_n   (arst_n),
			.select   (mul_select[i]),
			.issue    (issue),
			.cdb      (cdb),
			.dispatch (mul_dispatch[i]),
			.busy     (mul_busy[i]),
			.accepted (mul_accept[i]),
			.released (mul_release[i])
		);
	end

	rs_free_counter #(
		.NUM_ADD (NUM_ADD),
		.NUM_MUL (NUM_MUL)
	) rs_free_counter_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.add_accept  (add_accept),
		.add_release (add_release),
		.mul_accept  (mul_accept),
		.mul_release (mul_release),
		.add_free    (add_free),
		.mul_free    (mul_free)
	);

	// counts are kept apart from the stations, both must move on the same edge
	assert property (@(posedge clk) disable iff (!arst_n)
		(int'(add_free) == NUM_ADD - $countones(add_busy)) &&
		(int'(mul_free) == NUM_MUL - $countones(mul_busy)));

endmodule

/* tb_rs_model.svh */
//############################################################################
// Reference model of the reservation stations
// Mirrors station state, operands and tags, and the free counts
//############################################################################
`ifndef TB_RS_MODEL_SVH
`define TB_RS_MODEL_SVH

localparam int M_IDLE    = 0;
localparam int M_WAIT    = 1;
localparam int M_READY   = 2;
localparam int M_EXECUTE = 3;

int                m_state [5];
rs_pkg::rs_op_t    m_op [5];
rs_pkg::rs_value_t m_vj [5];
rs_pkg::rs_value_t m_vk [5];
rs_pkg::rs_tag_t   m_qj [5];
rs_pkg::rs_tag_t   m_qk [5];
int                m_add_free;
int                m_mul_free;

function automatic rs_pkg::rs_tag_t station_tag(int s);
	if (s < 3) begin
		return rs_pkg::rs_tag_t'(rs_pkg::ADD_TAG_BASE + s);
	end
	return rs_pkg::rs_tag_t'(rs_pkg::MUL_TAG_BASE + s - 3);
endfunction

// lowest valid bus carrying a nonzero tag wins
function automatic logic bus_lookup(rs_pkg::rs_tag_t t, output rs_pkg::rs_value_t v);
	v = '0;
	if (t == 4'd0) begin
		return 1'b0;
	end
	for (int b = 0; b < rs_pkg::NUM_CDB; b++) begin
		if (cdb[b].valid && cdb[b].tag == t) begin
			v = cdb[b].value;
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

task automatic model_reset();
	for (int s = 0; s < 5; s++) begin
		m_state[s] = M_IDLE;
		m_qj[s]    = '0;
		m_qk[s]    = '0;
	end
	m_add_free = 3;
	m_mul_free = 2;
endtask

// one clock edge, using the inputs held during the cycle before it
task automatic model_advance();
	rs_pkg::rs_value_t wj;
	rs_pkg::rs_value_t wk;
	rs_pkg::rs_value_t wown;
	logic hj;
	logic hk;
	int   delta [2];
	delta[0] = 0;
	delta[1] = 0;
	for (int s = 0; s < 5; s++) begin
		case (m_state[s])
			M_IDLE: begin
				if (issue_valid && issue.target == station_tag(s)) begin
					hj = bus_lookup(issue.qj, wj);
					hk = bus_lookup(issue.qk, wk);
					m_op[s] = issue.op;
					m_qj[s] = (issue.qj == 4'd0 || hj) ? 4'd0 : issue.qj;
					m_qk[s] = (issue.qk == 4'd0 || hk) ? 4'd0 : issue.qk;
					m_vj[s] = (issue.qj == 4'd0) ? issue.vj : wj;
					m_vk[s] = (issue.qk == 4'd0) ? issue.vk : wk;
					m_state[s] = (m_qj[s] == 4'd0 && m_qk[s] == 4'd0) ? M_READY : M_WAIT;
					delta[s >= 3] -= 1;
				end
			end
			M_WAIT: begin
				if (bus_lookup(m_qj[s], wj)) begin
					m_vj[s] = wj;
					m_qj[s] = '0;
				end
				if (bus_lookup(m_qk[s], wk)) begin
					m_vk[s] = wk;
					m_qk[s] = '0;
				end
				if (m_qj[s] == 4'd0 && m_qk[s] == 4'd0) begin
					m_state[s] = M_READY;
				end
			end
			M_READY: m_state[s] = M_EXECUTE;
			default: begin
				if (bus_lookup(station_tag(s), wown)) begin
					m_state[s] = M_IDLE;
					delta[s >= 3] += 1;
				end
			end
		endcase
	end
	m_add_free += delta[0];
	m_mul_free += delta[1];
endtask

`endif

/* tb_rs_top.sv */
//############################################################################
// Testbench for the arithmetic reservation stations
// Directed and random issue and CDB traffic, checked every cycle
//############################################################################
`timescale 1ns/100ps

module tb_rs_top;

	localparam int CLK_PERIOD   = 10;
	localparam int TOTAL_CYCLES = 640;   // rough sum of all test lengths

	logic                                   clk;
	logic                                   arst_n;
	logic                                   issue_valid;
	rs_pkg::issue_t                         issue;
	rs_pkg::cdb_bus_t [rs_pkg::NUM_CDB-1:0] cdb;
	rs_pkg::dispatch_t [2:0]                add_dispatch;
	rs_pkg::dispatch_t [1:0]                mul_dispatch;
	logic [2:0]                             add_busy;
	logic [1:0]                             mul_busy;
	logic [1:0]                             add_free;
	logic [1:0]                             mul_free;
	rs_pkg::dispatch_t [4:0]                disp_all;
	logic [4:0]                             busy_all;

	integer seed = 68025;
	int     errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;

	`include "tb_rs_model.svh"

	rs_top #(.NUM_ADD(3), .NUM_MUL(2)) rs_top_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.cdb          (cdb),
		.add_dispatch (add_dispatch),
		.mul_dispatch (mul_dispatch),
		.add_busy     (add_busy),
		.mul_busy     (mul_busy),
		.add_free     (add_free),
		.mul_free     (mul_free)
	);

	assign disp_all = {mul_dispatch, add_dispatch};   // station index 0..4
	assign busy_all = {mul_busy, add_busy};

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int rand_range(int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic string station_name(int s);
		return (s < 3) ? $sformatf("add[%0d]", s) : $sformatf("mul[%0d]", s - 3);
	endfunction

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
		if (got !== exp) begin
			$display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, got);
			errors++;
		end
	endtask

	task automatic compare_outputs();
		for (int s = 0; s < 5; s++) begin
			check_value({station_name(s), " busy"}, m_state[s] != M_IDLE, busy_all[s]);
			check_value({station_name(s), " start"}, m_state[s] == M_READY, disp_all[s].start);
			if (m_state[s] == M_READY) begin
				check_value({station_name(s), " op"}, m_op[s], disp_all[s].op);
				check_value({station_name(s), " vj"}, m_vj[s], disp_all[s].vj);
				check_value({station_name(s), " vk"}, m_vk[s], disp_all[s].vk);
			end
		end
		check_value("add_free", m_add_free, add_free);
		check_value("mul_free", m_mul_free, mul_free);
	endtask

	// edge, model step, then look at the settled outputs
	task automatic tick();
		@(posedge clk);
		model_advance();
		#1;
		compare_outputs();
	endtask

	task automatic clear_inputs();
		issue_valid = 1'b0;
		issue       = '0;
		cdb         = '0;
	endtask

	task automatic drive_issue(rs_pkg::rs_tag_t target, rs_pkg::rs_op_t op,
		rs_pkg::rs_value_t vj, rs_pkg::rs_value_t vk, rs_pkg::rs_tag_t qj,
		rs_pkg::rs_tag_t qk);
		issue_valid = 1'b1;
		issue       = '{target: target, op: op, vj: vj, vk: vk, qj: qj, qk: qk};
	endtask

	task automatic drive_bus(int b, rs_pkg::rs_tag_t tag, rs_pkg::rs_value_t value);
		cdb[b] = '{valid: 1'b1, tag: tag, value: value};
	endtask

	// broadcast the own tag of every executing station until all are free
	task automatic release_busy();
		int guard;
		guard = 0;
		while ((m_state.sum() with (int'(item != M_IDLE))) != 0 && guard < 20) begin
			clear_inputs();
			for (int s = 0; s < 5; s++) begin
				if (m_state[s] == M_EXECUTE) begin
					drive_bus(s, station_tag(s), $random(seed));
				end
			end
			tick();
			guard++;
		end
		clear_inputs();
		if (guard == 20) begin
			$display("stations did not go idle after their own tags were broadcast");
			errors++;
		end
	endtask

	task automatic finish_test(string name, int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	initial begin
		int                e0;
		int                released [2];
		rs_pkg::rs_tag_t   qj;
		rs_pkg::rs_tag_t   qk;
		rs_pkg::rs_value_t wj;
		rs_pkg::rs_value_t wk;
		rs_pkg::rs_value_t vj;
		rs_pkg::rs_value_t vk;
		rs_pkg::rs_op_t    op;
		int                t;
		clk    = 1'b0;
		arst_n = 1'b0;
		clear_inputs();
		model_reset();
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;

		e0 = errors;
		for (int s = 0; s < 5; s++) begin
			op = rs_pkg::rs_op_t'(rand_range(8));
			vj = $random(seed);
			vk = $random(seed);
			drive_issue(station_tag(s), op, vj, vk, 4'd0, 4'd0);
			tick();
			clear_inputs();
			check_value({station_name(s), " start"}, 1, disp_all[s].start);
			check_value({station_name(s), " vj"}, vj, disp_all[s].vj);
			check_value({station_name(s), " vk"}, vk, disp_all[s].vk);
			check_value({station_name(s), " op"}, op, disp_all[s].op);
			if (s < 3) check_value("add_free", 2 - s, add_free);
			else check_value("mul_free", 4 - s, mul_free);
		end
		release_busy();
		finish_test("ready issue", e0);

		e0 = errors;
		for (int s = 0; s < 5; s++) begin
			qj = rs_pkg::rs_tag_t'(1 + rand_range(6));
			qk = rs_pkg::rs_tag_t'(1 + (qj % 6));   // a different load tag
			wj = $random(seed);
			wk = $random(seed);
			drive_issue(station_tag(s), 3'd5, $random(seed), $random(seed), qj, qk);
			tick();
			clear_inputs();
			drive_bus(rand_range(6), qj, wj);
			tick();
			clear_inputs();
			check_value({station_name(s), " start"}, 0, disp_all[s].start);
			drive_bus(rand_range(6), qk, wk);
			tick();
			clear_inputs();
			check_value({station_name(s), " start"}, 1, disp_all[s].start);
			check_value({station_name(s), " vj"}, wj, disp_all[s].vj);
			check_value({station_name(s), " vk"}, wk, disp_all[s].vk);
			release_busy();
		end
		finish_test("wait and capture", e0);

		e0 = errors;
		for (int s = 0; s < 5; s++) begin
			qj = rs_pkg::rs_tag_t'(1 + rand_range(6));
			wj = $random(seed);
			vk = $random(seed);
			drive_issue(station_tag(s), 3'd2, $random(seed), vk, qj, 4'd0);
			drive_bus(rand_range(6), qj, wj);
			tick();
			clear_inputs();
			check_value({station_name(s), " start"}, 1, disp_all[s].start);
			check_value({station_name(s), " vj"}, wj, disp_all[s].vj);
			check_value({station_name(s), " vk"}, vk, disp_all[s].vk);
		end
		tick();
		finish_test("forwarding at issue", e0);

		e0 = errors;
		released[0] = 0;
		released[1] = 0;
		drive_bus(5, 4'd1, $random(seed));   // no station waits on this load
		tick();
		clear_inputs();
		check_value("busy", 5'h1f, busy_all);
		check_value("add_free", 0, add_free);
		check_value("mul_free", 0, mul_free);
		for (int s = 0; s < 5; s++) begin
			drive_bus(rand_range(6), station_tag(s), $random(seed));
			tick();
			clear_inputs();
			released[s >= 3]++;
			check_value({station_name(s), " busy"}, 0, busy_all[s]);
			check_value("add_free", released[0], add_free);
			check_value("mul_free", released[1], mul_free);
		end
		finish_test("release", e0);

		e0 = errors;
		for (int c = 0; c < 500; c++) begin
			clear_inputs();
			if (rand_range(2) == 0) begin
				t  = rand_range(6);
				qj = (rand_range(2) == 0) ? 4'd0 : rs_pkg::rs_tag_t'(1 + rand_range(11));
				qk = (rand_range(2) == 0) ? 4'd0 : rs_pkg::rs_tag_t'(1 + rand_range(11));
				if (t == 5) begin
					drive_issue(rs_pkg::rs_tag_t'(12 + rand_range(4)), 3'd1,
						$random(seed), $random(seed), qj, qk);
				end else if (m_state[t] == M_IDLE) begin
					drive_issue(station_tag(t), rs_pkg::rs_op_t'(rand_range(8)),
						$random(seed), $random(seed), qj, qk);
				end
			end
			for (int b = 0; b < rs_pkg::NUM_CDB; b++) begin
				if (rand_range(4) == 0) begin
					drive_bus(b, rs_pkg::rs_tag_t'(1 + rand_range(11)), $random(seed));
				end
			end
			tick();
		end
		clear_inputs();
		finish_test("random mix", e0);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(TOTAL_CYCLES * 20 * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Some tests failed");
		$finish;
	end

endmodule

/* src.f */
+incdir+.
rs_pkg.sv
cdb_snoop.sv
rs_station.sv
rs_free_counter.sv
rs_top.sv
tb_rs_top.sv

/* Makefile */
# Verilator build and run of the reservation station testbench

VERILATOR ?= verilator
TOP       ?= tb_rs_top
DUT_TOP   ?= rs_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(DUT_TOP) \
		rs_pkg.sv cdb_snoop.sv rs_station.sv rs_free_counter.sv rs_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
